// File: Bender.yml
package:
  name: datamem

sources:
  - include_dirs:
      - .
    files:
      - dataMemPkg.sv
      - dataMemory.sv
      - loadStoreUnit.sv
      - memCtrlRegs.sv
      - dataMemTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - dataMemTb.sv

// File: dataMemPkg.sv
`include "dataMem_config.svh"

package dataMemPkg;

  // Access size of a processor load or store
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } accessSizeT;

  // Processor request, held until done
  typedef struct packed {
    logic                   valid;
    logic                   write;
    accessSizeT             size;
    logic                   isSigned;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
  } memReqT;

  // Response back to the processor
  typedef struct packed {
    logic                   done;
    logic                   fault;
    logic [`DATA_WIDTH-1:0] rdata;
  } memRspT;

  //------------------------------------------------
  // Wishbone classic
  //------------------------------------------------
  // Master side outputs
  typedef struct packed {
    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [`DATA_WIDTH/8-1:0]    sel;
    logic [`WORD_ADDR_WIDTH-1:0] adr;
    logic [`DATA_WIDTH-1:0]      dat;
  } wbReqT;

  // Slave side outputs
  typedef struct packed {
    logic                   ack;
    logic [`DATA_WIDTH-1:0] dat;
  } wbRspT;

  // Write protection setup from the control registers
  typedef struct packed {
    logic                        enable;
    logic [`WORD_ADDR_WIDTH-1:0] limit;
  } protectCfgT;

endpackage

// File: dataMemTb.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMemTb import dataMemPkg::*; ();

  localparam int NumPatterns = 26;
  // op, size, isSigned, addr, wdata, expected rdata, expected fault
  localparam int PatFields = 7;
  localparam int NumRandom = 40;
  // Store, load and late readback per random address
  localparam int NumRandomAccesses = 3 * NumRandom;
  localparam int WatchdogCycles = (NumPatterns + NumRandomAccesses) * 6 + 200;
  localparam int MemBytes = `MEM_DEPTH * 4;
  localparam int MaxDoneWait = 3;

  logic   begintest;
  logic   rstN;
  memReqT req;
  memRspT rsp;
  wbReqT  cfgReq;
  wbRspT  cfgRsp;

  logic [31:0] patWords [NumPatterns*PatFields];
  // Byte mirror of the data memory
  logic [7:0]  refMem [MemBytes];
  logic [31:0] randAddrs [$];
  integer      seed;
  int          errorCount;
  int          testErrors;
  int          passCount;
  int          failCount;
  int          expectedFaults;

  dataMemTop uut (
    .begintest (begintest),
    .rstN      (rstN),
    .req       (req),
    .rsp       (rsp),
    .cfgReq    (cfgReq),
    .cfgRsp    (cfgRsp)
  );

  // 100 ns clock
  initial begin
    begintest = 1'b0;
    forever #50 begintest = ~begintest;
  end

  // Watchdog sized from the number of accesses
  initial begin
    repeat (WatchdogCycles) @(posedge begintest);
    $display("Timeout: run did not finish within %0d clock cycles", WatchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

  //------------------------------------------------
  // Checking and bookkeeping
  //------------------------------------------------
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finishTest(input string name);
    if (errorCount == testErrors) begin
      passCount++;
      $display("%s: ok", name);
    end else begin
      failCount++;
      $display("%s: %0d mismatches", name, errorCount - testErrors);
    end
    testErrors = errorCount;
  endtask

  //------------------------------------------------
  // Reference model with little endian lanes
  //------------------------------------------------
  function automatic logic [31:0] modelLoad(input logic [31:0] addr, input logic [1:0] size,
                                            input logic isSigned);
    int base;
    // Upper address bits wrap
    base = addr % MemBytes;
    case (size)
      2'd0: return {{24{isSigned & refMem[base][7]}}, refMem[base]};
      2'd1: return {{16{isSigned & refMem[base+1][7]}}, refMem[base+1], refMem[base]};
      default: return {refMem[base+3], refMem[base+2], refMem[base+1], refMem[base]};
    endcase
  endfunction

  function automatic void modelStore(input logic [31:0] addr, input logic [1:0] size,
                                     input logic [31:0] wdata);
    int base;
    int count;
    base = addr % MemBytes;
    count = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
    for (int i = 0; i < count; i++) begin
      refMem[base+i] = wdata[i*8 +: 8];
    end
  endfunction

  //------------------------------------------------
  // Bus drivers called right after a falling edge
  //------------------------------------------------
  task automatic memAccess(input logic write, input logic [1:0] size, input logic isSigned,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic fault, output int cycles);
    req.valid = 1'b1;
    req.write = write;
    req.size = accessSizeT'(size);
    req.isSigned = isSigned;
    req.addr = addr;
    req.wdata = wdata;
    cycles = 0;
    do begin
      @(negedge begintest);
      cycles++;
    end while (!rsp.done && cycles < MaxDoneWait);
    rdata = rsp.rdata;
    fault = rsp.fault;
    if (!rsp.done) begin
      errorCount++;
      $display("Missing done: no response within %0d cycles of the request to address %h",
               MaxDoneWait, addr);
    end
    req.valid = 1'b0;
    // Unit is back in idle one edge later
    @(negedge begintest);
    checkValue("rsp.done", rsp.done, 32'd0);
  endtask

  task automatic runAccess(input logic write, input logic [1:0] size, input logic isSigned,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] expRdata, input logic expFault);
    logic [31:0] rdata;
    logic        fault;
    int          cycles;
    memAccess(write, size, isSigned, addr, wdata, rdata, fault, cycles);
    // Faults answer in 1 cycle and bus accesses in 3
    checkValue("done latency", cycles, expFault ? 32'd1 : 32'd3);
    checkValue("rsp.fault", fault, expFault);
    checkValue("rsp.rdata", rdata, expRdata);
    if (expFault) begin
      expectedFaults++;
    end else if (write) begin
      modelStore(addr, size, wdata);
    end
  endtask

  task automatic cfgAccess(input logic we, input logic [29:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    int cycles;
    cfgReq.cyc = 1'b1;
    cfgReq.stb = 1'b1;
    cfgReq.we = we;
    cfgReq.sel = 4'hF;
    cfgReq.adr = adr;
    cfgReq.dat = dat;
    cycles = 0;
    do begin
      @(negedge begintest);
      cycles++;
    end while (!cfgRsp.ack && cycles < 3);
    rdata = cfgRsp.dat;
    if (!cfgRsp.ack) begin
      errorCount++;
      $display("Missing ack: control port did not answer at offset %0d", adr);
    end else begin
      checkValue("cfgRsp.ack latency", cycles, 32'd1);
    end
    cfgReq.cyc = 1'b0;
    cfgReq.stb = 1'b0;
    @(negedge begintest);
  endtask

  task automatic checkReg(input logic [29:0] adr, input logic [31:0] expected,
                          input string name);
    logic [31:0] rdata;
    cfgAccess(1'b0, adr, 32'd0, rdata);
    checkValue(name, rdata, expected);
  endtask

  task automatic runPattern(input int idx);
    int          b;
    logic [31:0] rdata;
    b = idx * PatFields;
    case (patWords[b])
      32'd0, 32'd1: begin
        // Pattern file must agree with the byte model
        if (patWords[b] == 32'd1 && patWords[b+6] == 32'd0) begin
          checkValue("model rdata",
                     modelLoad(patWords[b+3], patWords[b+1][1:0], patWords[b+2][0]),
                     patWords[b+5]);
        end
        runAccess(patWords[b] == 32'd0, patWords[b+1][1:0], patWords[b+2][0],
                  patWords[b+3], patWords[b+4], patWords[b+5], patWords[b+6][0]);
      end
      // Config write with the register offset in addr
      32'd2: cfgAccess(1'b1, patWords[b+3][29:0], patWords[b+4], rdata);
      default: begin
        errorCount++;
        $display("Pattern %0d has an unknown operation code", idx);
      end
    endcase
  endtask

  //------------------------------------------------
  // Test sequence
  //------------------------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    seed = 32'h6d02;
    errorCount = 0;
    testErrors = 0;
    passCount = 0;
    failCount = 0;
    expectedFaults = 0;
    rstN = 1'b0;
    req = '0;
    cfgReq = '0;
    $readmemh("dataMem_patterns.mem", patWords);
    if ($isunknown(patWords[NumPatterns*PatFields-1])) begin
      errorCount++;
      $display("Pattern file is missing or shorter than %0d lines", NumPatterns);
    end

    // Reset held for 4 rising edges
    repeat (4) @(negedge begintest);
    // Outputs sampled while reset is still applied
    checkValue("rsp.done", rsp.done, 32'd0);
    checkValue("cfgRsp.ack", cfgRsp.ack, 32'd0);
    rstN = 1'b1;
    @(negedge begintest);
    checkReg(`REG_LIMIT, 32'd0, "REG_LIMIT");
    checkReg(`REG_ENABLE, 32'd0, "REG_ENABLE");
    checkReg(`REG_FAULTS, 32'd0, "REG_FAULTS");
    finishTest("reset state");

    // Random aligned words including wrapped addresses
    for (int i = 0; i < NumRandom; i++) begin
      addr = $random(seed);
      addr[1:0] = 2'b00;
      data = $random(seed);
      runAccess(1'b1, 2'd2, 1'b0, addr, data, 32'd0, 1'b0);
      runAccess(1'b0, 2'd2, 1'b0, addr, 32'd0, data, 1'b0);
      randAddrs.push_back(addr);
    end
    // Earlier words read back since later writes may alias
    foreach (randAddrs[i]) begin
      runAccess(1'b0, 2'd2, 1'b0, randAddrs[i], 32'd0, modelLoad(randAddrs[i], 2'd2, 1'b0),
                1'b0);
    end
    finishTest("random word store/load");

    // Lanes, extension, misalignment and protection
    for (int p = 0; p < NumPatterns; p++) begin
      runPattern(p);
      finishTest($sformatf("pattern %0d", p));
    end

    // Control port readback
    checkReg(`REG_FAULTS, expectedFaults, "REG_FAULTS");
    cfgAccess(1'b1, `REG_LIMIT, 32'h0000_0123, rdata);
    checkReg(`REG_LIMIT, 32'h0000_0123, "REG_LIMIT");
    cfgAccess(1'b1, `REG_ENABLE, 32'd1, rdata);
    checkReg(`REG_ENABLE, 32'd1, "REG_ENABLE");
    cfgAccess(1'b1, `REG_FAULTS, 32'd0, rdata);
    checkReg(`REG_FAULTS, 32'd0, "REG_FAULTS");
    finishTest("control readback");

    $display("Summary: %0d tests ok, %0d tests with mismatches, %0d mismatches in total",
             passCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dataMemTop.sv
`timescale 1ns/1ps

module dataMemTop import dataMemPkg::*; (
  input  logic   begintest,
  input  logic   rstN,
  input  memReqT req,
  output memRspT rsp,
  input  wbReqT  cfgReq,
  output wbRspT  cfgRsp
);

  //------------------------------------------------
  // Internal buses
  //------------------------------------------------
  // Load/store unit to memory
  wbReqT      memWbReq;
  wbRspT      memWbRsp;
  // Registers to load/store unit and back
  protectCfgT protectCfg;
  logic       faultPulse;

  // Request sequencer, bus master
  loadStoreUnit lsu (
    .begintest  (begintest),
    .rstN       (rstN),
    .req        (req),
    .rsp        (rsp),
    .protectCfg (protectCfg),
    .wbReq      (memWbReq),
    .wbRsp      (memWbRsp),
    .faultPulse (faultPulse)
  );

  // Data store
  dataMemory mem (
    .begintest (begintest),
    .rstN      (rstN),
    .wbReq     (memWbReq),
    .wbRsp     (memWbRsp)
  );

  // Protection setup and fault count on the control port
  memCtrlRegs ctrlRegs (
    .begintest  (begintest),
    .rstN       (rstN),
    .cfgReq     (cfgReq),
    .cfgRsp     (cfgRsp),
    .protectCfg (protectCfg),
    .faultPulse (faultPulse)
  );

endmodule

// File: dataMem_config.svh
`ifndef DATA_MEM_CONFIG_SVH
`define DATA_MEM_CONFIG_SVH

//------------------------------------------------
// Datapath widths
//------------------------------------------------
// Processor word width
`define DATA_WIDTH 32
// Byte address width on the processor side
`define ADDR_WIDTH 32
// Wishbone word address, byte offset bits dropped
`define WORD_ADDR_WIDTH (`ADDR_WIDTH - 2)

// Number of memory words, upper address bits wrap
`define MEM_DEPTH 256

//------------------------------------------------
// Control port register map (word offsets)
//------------------------------------------------
`define REG_LIMIT 0
`define REG_ENABLE 1
`define REG_FAULTS 2

`endif

// File: dataMem_patterns.mem
// op(0 write, 1 read, 2 config write) size(0 byte, 1 half, 2 word) isSigned addr wdata
// expected rdata, expected fault; for config writes addr is the register offset
0 2 0 00000100 11223344 00000000 0
0 0 0 00000101 000000A5 00000000 0
1 2 0 00000100 00000000 1122A544 0
1 0 1 00000101 00000000 FFFFFFA5 0
1 0 0 00000101 00000000 000000A5 0
0 1 0 00000102 0000BEEF 00000000 0
1 2 0 00000100 00000000 BEEFA544 0
1 1 1 00000102 00000000 FFFFBEEF 0
1 1 0 00000102 00000000 0000BEEF 0
1 1 1 00000100 00000000 FFFFA544 0
1 0 1 00000100 00000000 00000044 0
0 2 0 00000200 CAFEF00D 00000000 0
0 1 0 00000201 00001234 00000000 1
0 2 0 00000202 55667788 00000000 1
1 2 0 00000203 00000000 00000000 1
1 2 0 00000200 00000000 CAFEF00D 0
0 2 0 00000080 0BADBEEF 00000000 0
2 0 0 00000000 00000040 00000000 0
2 0 0 00000001 00000001 00000000 0
0 2 0 00000080 DEADDEAD 00000000 1
1 2 0 00000080 00000000 0BADBEEF 0
0 2 0 00000100 77665544 00000000 0
1 2 0 00000100 00000000 77665544 0
2 0 0 00000001 00000000 00000000 0
0 2 0 00000080 DEADDEAD 00000000 0
1 2 0 00000080 00000000 DEADDEAD 0

// File: dataMemory.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMemory import dataMemPkg::*; (
  input  logic  begintest,
  input  logic  rstN,
  input  wbReqT wbReq,
  output wbRspT wbRsp
);

  localparam int DataWidth = `DATA_WIDTH;
  localparam int SelWidth = `DATA_WIDTH / 8;
  localparam int IdxWidth = $clog2(`MEM_DEPTH);

  // Word storage, no reset on contents
  logic [DataWidth-1:0] memArray [`MEM_DEPTH];

  logic [IdxWidth-1:0]  wordIdx;
  logic                 strobe;
  logic                 ackQ;
  logic [DataWidth-1:0] rdataQ;

  //------------------------------------------------
  // Address decode and strobe
  //------------------------------------------------
  // Only the low word address bits index the array
  assign wordIdx = wbReq.adr[IdxWidth-1:0];

  // Fresh strobe only
  // ack already out means this cycle was served
  assign strobe = wbReq.cyc && wbReq.stb && !ackQ;

  //------------------------------------------------
  // Ack generation
  //------------------------------------------------
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      ackQ <= 1'b0;
    end else begin
      // One cycle ack, one edge after the strobe
      ackQ <= strobe;
    end
  end

  //------------------------------------------------
  // Array access
  //------------------------------------------------
  always_ff @(posedge begintest) begin
    if (strobe) begin
      if (wbReq.we) begin
        // Byte lane merge
        for (int lane = 0; lane < SelWidth; lane++) begin
          if (wbReq.sel[lane]) begin
            memArray[wordIdx][lane*8 +: 8] <= wbReq.dat[lane*8 +: 8];
          end
        end
      end else begin
        // Whole word out, lane pick is up to the master
        rdataQ <= memArray[wordIdx];
      end
    end
  end

  // Slave outputs
  assign wbRsp.ack = ackQ;
  assign wbRsp.dat = rdataQ;

endmodule

// File: files.f
+incdir+.
dataMemPkg.sv
dataMemory.sv
loadStoreUnit.sv
memCtrlRegs.sv
dataMemTop.sv
dataMemTb.sv

// File: loadStoreUnit.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module loadStoreUnit import dataMemPkg::*; (
  input  logic       begintest,
  input  logic       rstN,
  input  memReqT     req,
  output memRspT     rsp,
  input  protectCfgT protectCfg,
  output wbReqT      wbReq,
  input  wbRspT      wbRsp,
  output logic       faultPulse
);

  localparam int DataWidth = `DATA_WIDTH;
  localparam int SelWidth = `DATA_WIDTH / 8;
  localparam int WordAddrWidth = `WORD_ADDR_WIDTH;

  // Sequencer states
  typedef enum logic [1:0] {
    stateIdle,
    stateBus,
    stateRespond
  } lsuStateT;

  lsuStateT state;

  // Request decode
  logic                     accept;
  logic [1:0]               offset;
  logic [WordAddrWidth-1:0] wordAddr;
  logic                     misaligned;
  logic                     protectHit;
  logic                     accessFault;
  logic [SelWidth-1:0]      selNext;
  logic [DataWidth-1:0]     storeData;

  // Bus cycle registers
  logic                     cycQ;
  logic                     weQ;
  logic [SelWidth-1:0]      selQ;
  logic [WordAddrWidth-1:0] adrQ;
  logic [DataWidth-1:0]     datQ;

  // Load context kept for the response
  logic [1:0]               offsetQ;
  accessSizeT               sizeQ;
  logic                     signedQ;
  logic [7:0]               byteLane;
  logic [15:0]              halfLane;
  logic [DataWidth-1:0]     loadData;

  // Response registers
  logic                     doneQ;
  logic                     faultQ;
  logic [DataWidth-1:0]     rdataQ;

  //------------------------------------------------
  // Request checks
  //------------------------------------------------
  // valid ignored while busy or in the done cycle
  assign accept = (state == stateIdle) && req.valid;
  assign offset = req.addr[1:0];
  assign wordAddr = req.addr[`ADDR_WIDTH-1:2];

  always_comb begin
    case (req.size)
      sizeByte: misaligned = 1'b0;
      sizeHalf: misaligned = offset[0];
      default:  misaligned = (offset != 2'b00);
    endcase
  end

  // Stores below the limit are blocked when protection is on
  assign protectHit = req.write && protectCfg.enable && (wordAddr < protectCfg.limit);
  assign accessFault = misaligned || protectHit;

  // Counter bumps on the same edge that registers done
  assign faultPulse = accept && accessFault;

  //------------------------------------------------
  // Store lanes
  //------------------------------------------------
  always_comb begin
    case (req.size)
      sizeByte: begin
        selNext = 4'b0001 << offset;
        // Same byte on every lane
        storeData = {4{req.wdata[7:0]}};
      end
      sizeHalf: begin
        selNext = 4'b0011 << offset;
        storeData = {2{req.wdata[15:0]}};
      end
      default: begin
        selNext = 4'b1111;
        storeData = req.wdata;
      end
    endcase
  end

  //------------------------------------------------
  // Load extraction and extension
  //------------------------------------------------
  assign byteLane = wbRsp.dat[{offsetQ, 3'b000} +: 8];
  assign halfLane = offsetQ[1] ? wbRsp.dat[31:16] : wbRsp.dat[15:0];

  always_comb begin
    case (sizeQ)
      sizeByte: loadData = {{(DataWidth-8){signedQ & byteLane[7]}}, byteLane};
      sizeHalf: loadData = {{(DataWidth-16){signedQ & halfLane[15]}}, halfLane};
      default:  loadData = wbRsp.dat;
    endcase
  end

  //------------------------------------------------
  // Sequencer
  //------------------------------------------------
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      state <= stateIdle;
      cycQ <= 1'b0;
      doneQ <= 1'b0;
      faultQ <= 1'b0;
    end else begin
      // done is a single cycle pulse
      doneQ <= 1'b0;
      case (state)
        stateIdle: begin
          if (accept && accessFault) begin
            // No bus cycle on a fault
            doneQ <= 1'b1;
            faultQ <= 1'b1;
            state <= stateRespond;
          end else if (accept) begin
            cycQ <= 1'b1;
            faultQ <= 1'b0;
            state <= stateBus;
          end
        end
        stateBus: begin
          // Drop cyc/stb after the ack
          if (wbRsp.ack) begin
            cycQ <= 1'b0;
            doneQ <= 1'b1;
            state <= stateRespond;
          end
        end
        default: begin
          state <= stateIdle;
        end
      endcase
    end
  end

  // Bus fields and load context, captured at accept
  always_ff @(posedge begintest) begin
    if (accept) begin
      weQ <= req.write;
      selQ <= selNext;
      adrQ <= wordAddr;
      datQ <= storeData;
      offsetQ <= offset;
      sizeQ <= req.size;
      signedQ <= req.isSigned;
    end
    // Faults and stores return zero
    if (accept && accessFault) begin
      rdataQ <= '0;
    end else if (state == stateBus && wbRsp.ack) begin
      rdataQ <= weQ ? '0 : loadData;
    end
  end

  // Master outputs, stb tracks cyc
  assign wbReq.cyc = cycQ;
  assign wbReq.stb = cycQ;
  assign wbReq.we = weQ;
  assign wbReq.sel = selQ;
  assign wbReq.adr = adrQ;
  assign wbReq.dat = datQ;

  assign rsp.done = doneQ;
  assign rsp.fault = faultQ;
  assign rsp.rdata = rdataQ;

endmodule

// File: memCtrlRegs.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module memCtrlRegs import dataMemPkg::*; (
  input  logic       begintest,
  input  logic       rstN,
  input  wbReqT      cfgReq,
  output wbRspT      cfgRsp,
  output protectCfgT protectCfg,
  input  logic       faultPulse
);

  localparam int DataWidth = `DATA_WIDTH;
  localparam int WordAddrWidth = `WORD_ADDR_WIDTH;

  logic                     strobe;
  logic                     wrEn;
  logic                     ackQ;
  logic [DataWidth-1:0]     rdataQ;
  logic [DataWidth-1:0]     readMux;

  // Register contents
  logic [WordAddrWidth-1:0] limitQ;
  logic                     enableQ;
  logic [DataWidth-1:0]     faultCountQ;

  //------------------------------------------------
  // Slave handshake
  //------------------------------------------------
  // One ack per cycle, never repeated
  assign strobe = cfgReq.cyc && cfgReq.stb && !ackQ;
  assign wrEn = strobe && cfgReq.we;

  //------------------------------------------------
  // Register writes and fault counter
  //------------------------------------------------
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      ackQ <= 1'b0;
      limitQ <= '0;
      enableQ <= 1'b0;
      faultCountQ <= '0;
    end else begin
      ackQ <= strobe;
      if (wrEn && cfgReq.adr == `REG_LIMIT) begin
        limitQ <= cfgReq.dat[WordAddrWidth-1:0];
      end
      if (wrEn && cfgReq.adr == `REG_ENABLE) begin
        enableQ <= cfgReq.dat[0];
      end
      // Clear beats a fault in the same cycle
      if (wrEn && cfgReq.adr == `REG_FAULTS) begin
        faultCountQ <= '0;
      end else if (faultPulse && faultCountQ != '1) begin
        // Saturates at all ones
        faultCountQ <= faultCountQ + 1'b1;
      end
    end
  end

  //------------------------------------------------
  // Readback
  //------------------------------------------------
  always_comb begin
    case (cfgReq.adr)
      `REG_LIMIT:  readMux = DataWidth'(limitQ);
      `REG_ENABLE: readMux = DataWidth'(enableQ);
      `REG_FAULTS: readMux = faultCountQ;
      // Unmapped offsets read zero
      default:     readMux = '0;
    endcase
  end

  // Read word lands together with ack
  always_ff @(posedge begintest) begin
    if (strobe && !cfgReq.we) begin
      rdataQ <= readMux;
    end
  end

  assign cfgRsp.ack = ackQ;
  assign cfgRsp.dat = rdataQ;

  // Live setup toward the load/store unit
  assign protectCfg.enable = enableQ;
  assign protectCfg.limit = limitQ;

endmodule
